// File: compile.f
+incdir+design
design/rv_pkg.sv
design/idu.sv
design/regfile.sv
design/exu.sv
design/lsu.sv
design/csr_file.sv
design/rv_core.sv
tests/rv_checker.sv
tests/tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0 -Wno-fatal
TOP       = tb_rv_core
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

	import rv_pkg::*;

	logic          clk;
	logic          rst_n;
	logic          req;
	rv_pkg::inst_t inst;
	logic          ack;
	logic [31:0]   retire_pc;
	logic [4:0]    retire_rd;
	logic [31:0]   retire_data;
	int            errors;
	int            retired;
	int            err_mark;
	int            tests;
	logic [31:0]   seed;
	logic          timed_out;

	rv_core rv_core_inst (.clk, .rst_n, .req, .inst, .ack, .retire_pc, .retire_rd,
		.retire_data);

	rv_checker checker_inst (.clk, .rst_n, .req, .inst, .ack, .retire_pc, .retire_rd,
		.retire_data, .errors, .retired);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] rnd();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic logic [4:0] xr(input logic [2:0] n);
		return {2'b00, n}; // x0..x7 only
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [31:0] rand_alu();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r  = rnd();
		f3 = r[2:0];
		f7 = (r[4] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
		if (r[3])
			return enc_r(f7, xr(r[7:5]), xr(r[10:8]), f3, xr(r[13:11]));
		if (f3 == 3'b001 || f3 == 3'b101)
			return enc_i({f7, r[18:14]}, xr(r[10:8]), f3, xr(r[13:11]), OP_IMM);
		return enc_i(r[31:20], xr(r[10:8]), f3, xr(r[13:11]), OP_IMM);
	endfunction

	// base register x1 holds 0 so offsets 0..63 stay inside the prefilled words
	function automatic logic [31:0] rand_mem();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [2:0]  dst;
		logic [11:0] off;
		r   = rnd();
		f3  = (r[4:3] == 2'b11) ? 3'b010 : {1'b0, r[4:3]};
		off = {6'b0, r[10:5]};
		if (f3 == 3'b001)
			off[0] = 1'b0;
		if (f3 == 3'b010)
			off[1:0] = 2'b00;
		if (r[11])
			return enc_s(off, xr(r[14:12]), 5'd1, f3);
		dst = (r[2:1] == 2'b00) ? {2'b01, r[0]} : r[2:0]; // keep x1 intact
		if (f3 != 3'b010)
			f3[2] = r[15];
		return enc_i(off, 5'd1, f3, xr(dst), OP_LOAD);
	endfunction

	function automatic logic [31:0] rand_flow();
		logic [31:0] r;
		logic [12:0] off;
		logic [2:0]  f3;
		r   = rnd();
		off = {8'b0, r[6:4], 2'b00} - 13'd16;
		f3  = r[9:7];
		if (f3[2:1] == 2'b01)
			f3[2] = 1'b1;
		case (r[2:0])
			3'd4: return enc_j({{8{off[12]}}, off}, xr(r[18:16]));
			3'd5: return enc_i(r[31:20], xr(r[12:10]), 3'b000, xr(r[18:16]), OP_JALR);
			3'd6: return {r[31:12], xr(r[18:16]), OP_LUI};
			3'd7: return {r[31:12], xr(r[18:16]), OP_AUIPC};
			default: return enc_b(off, xr(r[15:13]), xr(r[12:10]), f3);
		endcase
	endfunction

	function automatic logic [31:0] rand_csr();
		logic [31:0] r;
		logic [11:0] csr;
		r = rnd();
		case (r[1:0])
			2'd0: csr = CSR_MSTATUS;
			2'd1: csr = CSR_MTVEC;
			2'd2: csr = CSR_MEPC;
			default: csr = CSR_MCAUSE;
		endcase
		if (r[4:2] == 3'b000)
			csr = 12'h7c0; // not implemented
		return enc_i(csr, xr(r[8:6]), r[5] ? 3'b010 : 3'b001, xr(r[11:9]), OP_SYSTEM);
	endfunction

	// four-phase handshake entered and left 1 ns after a rising edge
	task automatic issue(input logic [31:0] word);
		int n;
		if (timed_out)
			return;
		req  = 1'b1;
		inst = word;
		n    = 0;
		while (ack !== 1'b1 && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ack !== 1'b1) begin
			$display("handshake timed out: ack did not rise within 20 cycles");
			timed_out = 1'b1;
			return;
		end
		req = 1'b0;
		n   = 0;
		while (ack !== 1'b0 && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ack !== 1'b0) begin
			$display("handshake timed out: ack did not fall within 20 cycles");
			timed_out = 1'b1;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s done with %0d errors", name, errors - err_mark);
		err_mark = errors;
		tests++;
	endtask

	initial begin
		logic [31:0] r;
		seed      = 32'hf31b;
		rst_n     = 1'b0;
		req       = 1'b0;
		inst      = '0;
		err_mark  = 0;
		tests     = 0;
		timed_out = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		issue(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
		end_test("handshake");

		repeat (200) issue(rand_alu());
		end_test("alu");

		issue({20'b0, 5'd1, OP_LUI});
		issue(enc_i(12'd0, 5'd1, 3'b000, 5'd1, OP_IMM));
		for (int w = 0; w < 16; w++) begin
			r = rnd();
			issue({r[31:12], 5'd2, OP_LUI});
			issue(enc_i(r[11:0], 5'd2, 3'b000, 5'd2, OP_IMM));
			issue(enc_s(12'(w * 4), 5'd2, 5'd1, 3'b010));
		end
		repeat (150) issue(rand_mem());
		end_test("load_store");

		repeat (150) issue(rand_flow());
		end_test("control_flow");

		repeat (60) issue(rand_csr());
		end_test("csr");

		$display("%0d tests, %0d instructions retired, %0d errors", tests, retired, errors);
		if (errors == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_checker (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          req,
	input  rv_pkg::inst_t inst,
	input  logic          ack,
	input  logic [31:0]   retire_pc,
	input  logic [4:0]    retire_rd,
	input  logic [31:0]   retire_data,
	output int            errors,
	output int            retired
);

	import rv_pkg::*;

	logic [31:0] regs [32];
	logic [7:0]  mem [4*`RV_DMEM_WORDS]; // byte lanes
	logic [31:0] csrs [4];
	logic [31:0] pc;
	logic [31:0] exp_pc;
	logic [31:0] exp_data;
	logic [4:0]  exp_rd;
	logic        ack_q;
	logic        rise_due;
	logic        fall_due;
	logic        after_reset;

	initial begin
		errors  = 0;
		retired = 0;
		ack_q   = 1'b0;
	end

	task automatic flag(input string what, input logic [31:0] got, input logic [31:0] want);
		errors++;
		$display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	function automatic int csr_slot(input logic [11:0] a);
		case (a)
			CSR_MSTATUS: return 0;
			CSR_MTVEC:   return 1;
			CSR_MEPC:    return 2;
			CSR_MCAUSE:  return 3;
			default:     return -1;
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'b000: return alt ? x - y : x + y;
			3'b001: return x << y[4:0];
			3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b011: return (x < y) ? 32'd1 : 32'd0;
			3'b100: return x ^ y;
			3'b101: begin
				if (alt)
					return $signed(x) >>> y[4:0];
				return x >> y[4:0];
			end
			3'b110: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'b000: return x == y;
			3'b001: return x != y;
			3'b100: return $signed(x) < $signed(y);
			3'b101: return $signed(x) >= $signed(y);
			3'b110: return x < y;
			3'b111: return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	// advance the model by one instruction and set the expected retire record
	task automatic predict(input inst_t w);
		logic [31:0]              a;
		logic [31:0]              b;
		logic [31:0]              ii;
		logic [31:0]              v;
		logic [31:0]              nxt;
		logic [31:0]              addr;
		logic [31:0]              old;
		logic [`RV_DMEM_AW+1:0] ba;
		logic [2:0]               f3;
		logic                     wr;
		int                       slot;
		a    = regs[w.r.rs1];
		b    = regs[w.r.rs2];
		f3   = w.r.funct3;
		ii   = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
		v    = '0;
		wr   = 1'b0;
		nxt  = pc + 32'd4;
		case (w.r.opcode)
			OP_LUI: begin
				v  = {w.u.imm_31_12, 12'b0};
				wr = 1'b1;
			end
			OP_AUIPC: begin
				v  = pc + {w.u.imm_31_12, 12'b0};
				wr = 1'b1;
			end
			OP_JAL: begin
				v   = pc + 32'd4;
				wr  = 1'b1;
				nxt = pc + {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11,
					w.j.imm_10_1, 1'b0};
			end
			OP_JALR: begin
				v   = pc + 32'd4;
				wr  = 1'b1;
				nxt = (a + ii) & 32'hffff_fffe;
			end
			OP_BRANCH: begin
				if (taken_ref(f3, a, b))
					nxt = pc + {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5,
						w.b.imm_4_1, 1'b0};
			end
			OP_LOAD: begin
				addr = a + ii;
				ba   = addr[`RV_DMEM_AW+1:0];
				wr   = 1'b1;
				case (f3[1:0])
					2'b00: v = {{24{~f3[2] & mem[ba][7]}}, mem[ba]};
					2'b01: v = {{16{~f3[2] & mem[ba+1][7]}}, mem[ba+1], mem[ba]};
					default: v = {mem[ba+3], mem[ba+2], mem[ba+1], mem[ba]};
				endcase
			end
			OP_STORE: begin
				addr = a + {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
				ba   = addr[`RV_DMEM_AW+1:0];
				mem[ba] = b[7:0];
				if (f3 != 3'b000)
					mem[ba+1] = b[15:8];
				if (f3 == 3'b010) begin
					mem[ba+2] = b[23:16];
					mem[ba+3] = b[31:24];
				end
			end
			OP_IMM: v = alu_ref(f3, (f3 == 3'b101) && w.r.funct7[5], a, ii);
			OP_REG: v = alu_ref(f3, w.r.funct7[5], a, b);
			OP_SYSTEM: begin
				slot = csr_slot(w.i.imm_11_0);
				old  = (slot >= 0) ? csrs[slot] : 32'b0; // unimplemented reads zero
				v    = old;
				wr   = 1'b1;
				if (slot >= 0)
					csrs[slot] = (f3 == 3'b010) ? (a | old) : a;
			end
			default: ;
		endcase
		if (w.r.opcode == OP_IMM || w.r.opcode == OP_REG)
			wr = 1'b1;
		exp_pc   = nxt;
		exp_rd   = wr ? w.r.rd : 5'd0;
		exp_data = (wr && w.r.rd != 5'd0) ? v : 32'b0;
		if (wr && w.r.rd != 5'd0)
			regs[w.r.rd] = v;
		pc = nxt;
	endtask

	task automatic compare();
		retired++;
		if (retire_pc !== exp_pc)
			flag("retire_pc", retire_pc, exp_pc);
		if (retire_rd !== exp_rd)
			flag("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd});
		if (retire_data !== exp_data)
			flag("retire_data", retire_data, exp_data);
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n !== 1'b1) begin
			for (int k = 0; k < 32; k++)
				regs[k] = '0;
			for (int k = 0; k < 4; k++)
				csrs[k] = '0;
			pc          = `RV_RESET_PC;
			after_reset = 1'b1;
			rise_due    = 1'b0;
			fall_due    = 1'b0;
		end else begin
			if (after_reset) begin
				if (ack !== 1'b0)
					flag("ack after reset", {31'b0, ack}, 32'd0);
				if (retire_pc !== `RV_RESET_PC)
					flag("retire_pc after reset", retire_pc, `RV_RESET_PC);
				if (retire_rd !== 5'd0)
					flag("retire_rd after reset", {27'b0, retire_rd}, 32'd0);
				if (retire_data !== 32'b0)
					flag("retire_data after reset", retire_data, 32'b0);
				after_reset = 1'b0;
			end
			if (rise_due && ack !== 1'b1)
				flag("ack one cycle after req", {31'b0, ack}, 32'd1);
			if (fall_due && ack !== 1'b0)
				flag("ack one cycle after req low", {31'b0, ack}, 32'd0);
			if (ack === 1'b1 && ack_q === 1'b0)
				compare();
			rise_due = (req === 1'b1) && (ack === 1'b0);
			if (rise_due)
				predict(inst); // dut commits on the next rising edge
			fall_due = (ack === 1'b1) && (req === 1'b0);
		end
		ack_q = ack;
	end

endmodule

`default_nettype wire

// File: design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          req,
	input  rv_pkg::inst_t inst,
	output logic          ack,
	output logic [31:0]   retire_pc,
	output logic [4:0]    retire_rd,
	output logic [31:0]   retire_data
);

	logic [31:0] pc;
	logic        commit;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [4:0]  rs1, rs2, rd;
	logic [31:0] imm, src1, src2;
	logic [31:0] val, jump, mem_addr, wdata, rdata;
	logic [31:0] csr_val, csr_wdata, next_pc;
	logic        rd_we, jump_taken, mem_we, csr_we;
	logic [3:0]  wmask;

	assign commit  = req & ~ack; // one strobe per handshake
	assign next_pc = jump_taken ? jump : pc + 32'd4;

	idu idu_inst (.inst, .opcode, .funct3, .funct7, .rs1, .rs2, .rd, .imm);

	regfile regfile_inst (.clk, .rst_n, .rs1, .rs2, .rd, .we(commit & rd_we),
		.wdata(val), .src1, .src2);

	exu exu_inst (.opcode, .funct3, .funct7, .src1, .src2, .imm, .pc, .rdata, .csr_val,
		.val, .rd_we, .jump_taken, .jump, .mem_addr, .mem_we, .wmask, .wdata,
		.csr_we, .csr_wdata);

	lsu lsu_inst (.clk, .mem_addr, .wdata, .wmask, .we(commit & mem_we), .rdata);

	csr_file csr_file_inst (.clk, .rst_n, .addr(imm[11:0]), .we(commit & csr_we),
		.wdata(csr_wdata), .rdata(csr_val));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack         <= 1'b0;
			pc          <= `RV_RESET_PC;
			retire_pc   <= `RV_RESET_PC;
			retire_rd   <= '0;
			retire_data <= '0;
		end else if (commit) begin
			ack         <= 1'b1;
			pc          <= next_pc;
			retire_pc   <= next_pc;
			retire_rd   <= rd_we ? rd : 5'd0;
			retire_data <= (rd_we && rd != 5'd0) ? val : 32'b0; // x0 reports zero
		end else if (!req) begin
			ack <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [11:0] addr,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] rdata
);

	import rv_pkg::*;

	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (we) begin
			case (addr)
				CSR_MSTATUS: mstatus <= wdata;
				CSR_MTVEC:   mtvec   <= wdata;
				CSR_MEPC:    mepc    <= wdata;
				CSR_MCAUSE:  mcause  <= wdata;
				default: ; // unimplemented writes dropped
			endcase
		end
	end

	always_comb begin
		case (addr)
			CSR_MSTATUS: rdata = mstatus;
			CSR_MTVEC:   rdata = mtvec;
			CSR_MEPC:    rdata = mepc;
			CSR_MCAUSE:  rdata = mcause;
			default:     rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module lsu (
	input  logic        clk,
	input  logic [31:0] mem_addr,
	input  logic [31:0] wdata,
	input  logic [3:0]  wmask,
	input  logic        we,
	output logic [31:0] rdata
);

	logic [31:0]              mem [`RV_DMEM_WORDS];
	logic [`RV_DMEM_AW-1:0] idx;

	assign idx   = mem_addr[`RV_DMEM_AW+1:2]; // wraps modulo depth
	assign rdata = mem[idx];

	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < 4; b++) begin
				if (wmask[b])
					mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
	input  logic [6:0]  opcode,
	input  logic [2:0]  funct3,
	input  logic [6:0]  funct7,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	input  logic [31:0] pc,
	input  logic [31:0] rdata,
	input  logic [31:0] csr_val,
	output logic [31:0] val,
	output logic        rd_we,
	output logic        jump_taken,
	output logic [31:0] jump,
	output logic [31:0] mem_addr,
	output logic        mem_we,
	output logic [3:0]  wmask,
	output logic [31:0] wdata,
	output logic        csr_we,
	output logic [31:0] csr_wdata
);

	import rv_pkg::*;

	logic [31:0] op2;
	logic [4:0]  shamt;
	logic [31:0] alu_out;
	logic        br_taken;
	logic [31:0] ld_shift;

	assign op2      = (opcode == OP_REG) ? src2 : imm;
	assign shamt    = op2[4:0];
	assign mem_addr = src1 + imm;
	assign ld_shift = rdata >> {mem_addr[1:0], 3'b000}; // addressed lane to bit 0

	always_comb begin
		case (funct3)
			3'b000: begin
				if (opcode == OP_REG && funct7[5])
					alu_out = src1 - op2;
				else
					alu_out = src1 + op2;
			end
			3'b001: alu_out = src1 << shamt;
			3'b010: alu_out = {31'b0, $signed(src1) < $signed(op2)};
			3'b011: alu_out = {31'b0, src1 < op2};
			3'b100: alu_out = src1 ^ op2;
			3'b101: begin
				if (funct7[5])
					alu_out = $signed(src1) >>> shamt; // sra / srai
				else
					alu_out = src1 >> shamt;
			end
			3'b110: alu_out = src1 | op2;
			default: alu_out = src1 & op2;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000: br_taken = (src1 == src2);
			3'b001: br_taken = (src1 != src2);
			3'b100: br_taken = ($signed(src1) < $signed(src2));
			3'b101: br_taken = ($signed(src1) >= $signed(src2));
			3'b110: br_taken = (src1 < src2);
			3'b111: br_taken = (src1 >= src2);
			default: br_taken = 1'b0;
		endcase
	end

	always_comb begin
		val        = '0;
		rd_we      = 1'b0;
		jump_taken = 1'b0;
		jump       = pc + imm;
		mem_we     = 1'b0;
		wmask      = '0;
		wdata      = '0;
		csr_we     = 1'b0;
		csr_wdata  = '0;
		case (opcode)
			OP_LUI: begin
				val   = imm;
				rd_we = 1'b1;
			end
			OP_AUIPC: begin
				val   = pc + imm;
				rd_we = 1'b1;
			end
			OP_JAL: begin
				val        = pc + 32'd4;
				rd_we      = 1'b1;
				jump_taken = 1'b1;
			end
			OP_JALR: begin
				val        = pc + 32'd4;
				rd_we      = 1'b1;
				jump_taken = 1'b1;
				jump       = (src1 + imm) & ~32'd1;
			end
			OP_BRANCH: jump_taken = br_taken;
			OP_LOAD: begin
				rd_we = 1'b1;
				case (funct3)
					3'b000: val = {{24{ld_shift[7]}}, ld_shift[7:0]};
					3'b001: val = {{16{ld_shift[15]}}, ld_shift[15:0]};
					3'b010: val = rdata;
					3'b100: val = {24'b0, ld_shift[7:0]};
					3'b101: val = {16'b0, ld_shift[15:0]};
					default: rd_we = 1'b0; // reserved width
				endcase
			end
			OP_STORE: begin
				mem_we = 1'b1;
				case (funct3)
					3'b000: begin
						wmask = 4'b0001 << mem_addr[1:0];
						wdata = {4{src2[7:0]}};
					end
					3'b001: begin
						wmask = 4'b0011 << {mem_addr[1], 1'b0};
						wdata = {2{src2[15:0]}};
					end
					3'b010: begin
						wmask = 4'b1111;
						wdata = src2;
					end
					default: mem_we = 1'b0;
				endcase
			end
			OP_IMM, OP_REG: begin
				val   = alu_out;
				rd_we = 1'b1;
			end
			OP_SYSTEM: begin
				if (funct3 == 3'b001 || funct3 == 3'b010) begin
					val       = csr_val; // old value to rd
					rd_we     = 1'b1;
					csr_we    = 1'b1;
					csr_wdata = (funct3 == 3'b010) ? (src1 | csr_val) : src1;
				end
			end
			default: begin
				rd_we = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] src1,
	output logic [31:0] src2
);

	logic [31:0] regs [1:`RV_NUM_REGS-1]; // x0 not stored

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 1; k < `RV_NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu (
	input  rv_pkg::inst_t inst,
	output logic [6:0]    opcode,
	output logic [2:0]    funct3,
	output logic [6:0]    funct7,
	output logic [4:0]    rs1,
	output logic [4:0]    rs2,
	output logic [4:0]    rd,
	output logic [31:0]   imm
);

	import rv_pkg::*;

	assign opcode = inst.r.opcode;
	assign funct3 = inst.r.funct3;
	assign funct7 = inst.r.funct7;
	assign rs1    = inst.r.rs1;
	assign rs2    = inst.r.rs2;

	always_comb begin
		rd  = inst.r.rd;
		imm = '0;
		case (opcode)
			OP_LUI, OP_AUIPC: begin
				imm = {inst.u.imm_31_12, 12'b0};
			end
			OP_JAL: begin
				imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
				       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
			end
			OP_JALR, OP_LOAD, OP_IMM: begin
				imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
			end
			OP_STORE: begin
				rd  = '0; // no destination
				imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
			end
			OP_BRANCH: begin
				rd  = '0;
				imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
				       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
			end
			OP_SYSTEM: begin
				imm = {20'b0, inst.i.imm_11_0}; // raw csr number
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

endpackage

`default_nettype wire

// File: design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// pc value after reset
`define RV_RESET_PC 32'h8000_0000

// word organized data memory geometry
`define RV_DMEM_WORDS 256
`define RV_DMEM_AW 8

// architectural integer registers
`define RV_NUM_REGS 32

`endif
